/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = aluTb
FILELIST  = all.f
BUILD     = obj_dir
LOG       = sim.log
FAIL_MSG  = Errors found
PASS_MSG  = No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
source/aluPkg.sv
source/cmdDecoder.sv
source/seqControl.sv
source/stepCounter.sv
source/operandRegs.sv
source/addSubUnit.sv
source/aluTop.sv
tb/aluAsserts.sv
tb/aluTb.sv

/* source/addSubUnit.sv */
`default_nettype none

module addSubUnit import aluPkg::*; (
  input  logic CLK,
  input  logic RST,
  input  wordT regA,
  input  wordT regB,
  input  byteT dataByte,
  input  opT   op,
  input  logic signedMode,
  input  logic writeOrUseA,
  input  stepT stepIndex,
  input  logic flagEn,
  input  logic flagClr,
  output wordT sum,
  output logic overflow,
  output logic negative
);

  wordT dataExt;
  wordT operand;
  wordT addend;
  byteT mulShift;
  logic mulBit;
  logic subtract;
  logic carryOut;
  logic signedOvf;

  // Sign or zero extension of the data byte
  assign dataExt = signedMode ? {{(WordWidth-DataWidth){dataByte[DataWidth-1]}}, dataByte}
                              : {{(WordWidth-DataWidth){1'b0}}, dataByte};

  // Multiplier bit for the current step
  assign mulShift = dataByte >> stepIndex;
  assign mulBit   = mulShift[0];

  always_comb
  begin
    case (op)
      OpMul:   operand = mulBit ? regA : '0;
      default: operand = writeOrUseA ? regA : dataExt;
    endcase
  end

  ////////////////////////////////////////
  // Adder, subtract as B + ~x + 1
  assign subtract = (op == OpSub);
  assign addend   = subtract ? ~operand : operand;
  assign {carryOut, sum} = {1'b0, regB} + {1'b0, addend} + {{WordWidth{1'b0}}, subtract};

  // Both inputs agree in sign but the result does not
  assign signedOvf = (regB[WordWidth-1] == addend[WordWidth-1]) &&
                     (sum[WordWidth-1] != regB[WordWidth-1]);

  ////////////////////////////////////////
  // Status flags
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      overflow <= 1'b0;
      negative <= 1'b0;
    end
    else if (flagClr)
    begin
      overflow <= 1'b0;
      negative <= 1'b0;
    end
    else if (flagEn)
    begin
      if (signedMode)
      begin
        overflow <= signedOvf;
        negative <= sum[WordWidth-1];
      end
      else
      begin
        // Carry on add, borrow on subtract
        overflow <= !subtract && carryOut;
        negative <= subtract && !carryOut;
      end
    end
  end

endmodule

`default_nettype wire

/* source/aluPkg.sv */
`default_nettype none

package aluPkg;

  // Port and register widths
  localparam int DataWidth = 8;
  localparam int WordWidth = 16;

  typedef logic [DataWidth-1:0] byteT;
  typedef logic [WordWidth-1:0] wordT;
  typedef logic                 regSelT;
  typedef logic [1:0]           readSelT;
  typedef logic [3:0]           stepT;

  // Command operation, uio_in[6:5]
  typedef enum logic [1:0] {
    OpLoad = 2'b00,
    OpAdd  = 2'b01,
    OpSub  = 2'b10,
    OpMul  = 2'b11
  } opT;

  typedef enum logic [1:0] {
    Idle,
    Run,
    Step,
    Done
  } seqStateT;

  // Register and byte half selectors
  localparam regSelT SelRegA  = 1'b0;
  localparam regSelT SelRegB  = 1'b1;
  localparam regSelT SelHigh  = 1'b1;

  // P, N and done drive out, everything else is an input
  localparam byteT PinDirection = 8'b0001_1100;

endpackage

`default_nettype wire

/* source/aluTop.sv */
`default_nettype none

module aluTop import aluPkg::*; #(
  parameter int MulSteps = DataWidth
) (
  input  logic CLK,
  input  logic RST,
  input  byteT ui_in,
  input  byteT uio_in,
  output byteT uo_out,
  output byteT uio_out,
  output byteT uio_oe
);

  byteT   dataByte;
  opT     op;
  logic   signedMode;
  regSelT regSel;
  regSelT byteSel;
  logic   writeOrUseA;
  logic   startLevel;
  logic   startRise;

  logic loadEn;
  logic arithEn;
  logic mulStepEn;
  logic flagEn;
  logic flagClr;
  logic cntClr;
  logic cntEn;
  logic done;

  stepT stepIndex;
  logic lastStep;
  wordT regA;
  wordT regB;
  wordT sum;
  logic overflow;
  logic negative;

  ////////////////////////////////////////
  // Pin mapping
  assign uio_out = {3'b000, overflow, negative, done, 2'b00};
  assign uio_oe  = PinDirection;

  ////////////////////////////////////////
  // Control path
  cmdDecoder cmdDecoder_i (
    .CLK         (CLK),
    .RST         (RST),
    .ui_in       (ui_in),
    .uio_in      (uio_in),
    .dataByte    (dataByte),
    .op          (op),
    .signedMode  (signedMode),
    .regSel      (regSel),
    .byteSel     (byteSel),
    .writeOrUseA (writeOrUseA),
    .startLevel  (startLevel),
    .startRise   (startRise)
  );

  seqControl #(
    .MulSteps (MulSteps)
  ) seqControl_i (
    .CLK         (CLK),
    .RST         (RST),
    .op          (op),
    .writeOrUseA (writeOrUseA),
    .startLevel  (startLevel),
    .startRise   (startRise),
    .lastStep    (lastStep),
    .loadEn      (loadEn),
    .arithEn     (arithEn),
    .mulStepEn   (mulStepEn),
    .flagEn      (flagEn),
    .flagClr     (flagClr),
    .cntClr      (cntClr),
    .cntEn       (cntEn),
    .done        (done)
  );

  stepCounter #(
    .MulSteps (MulSteps)
  ) stepCounter_i (
    .CLK       (CLK),
    .RST       (RST),
    .cntClr    (cntClr),
    .cntEn     (cntEn),
    .stepIndex (stepIndex),
    .lastStep  (lastStep)
  );

  ////////////////////////////////////////
  // Data path
  operandRegs operandRegs_i (
    .CLK         (CLK),
    .RST         (RST),
    .dataByte    (dataByte),
    .regSel      (regSel),
    .byteSel     (byteSel),
    .writeOrUseA (writeOrUseA),
    .loadEn      (loadEn),
    .arithEn     (arithEn),
    .mulStepEn   (mulStepEn),
    .sum         (sum),
    .regA        (regA),
    .regB        (regB),
    .uo_out      (uo_out)
  );

  addSubUnit addSubUnit_i (
    .CLK         (CLK),
    .RST         (RST),
    .regA        (regA),
    .regB        (regB),
    .dataByte    (dataByte),
    .op          (op),
    .signedMode  (signedMode),
    .writeOrUseA (writeOrUseA),
    .stepIndex   (stepIndex),
    .flagEn      (flagEn),
    .flagClr     (flagClr),
    .sum         (sum),
    .overflow    (overflow),
    .negative    (negative)
  );

endmodule

`default_nettype wire

/* source/cmdDecoder.sv */
`default_nettype none

module cmdDecoder import aluPkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  byteT   ui_in,
  input  byteT   uio_in,
  output byteT   dataByte,
  output opT     op,
  output logic   signedMode,
  output regSelT regSel,
  output regSelT byteSel,
  output logic   writeOrUseA,
  output logic   startLevel,
  output logic   startRise
);

  // Bit 0 of the command byte carries nothing
  logic [DataWidth-1:1] cmdReg;
  logic                 startPrev;

  // Input registers
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      dataByte  <= '0;
      cmdReg    <= '0;
      startPrev <= 1'b0;
    end
    else
    begin
      dataByte  <= ui_in;
      cmdReg    <= uio_in[DataWidth-1:1];
      startPrev <= cmdReg[1];
    end
  end

  ////////////////////////////////////////
  // Command fields
  assign signedMode  = cmdReg[7];
  assign op          = opT'(cmdReg[6:5]);
  assign regSel      = cmdReg[4];
  assign byteSel     = cmdReg[3];
  assign writeOrUseA = cmdReg[2];
  assign startLevel  = cmdReg[1];

  // One cycle pulse on the first synchronized high
  assign startRise = startLevel & ~startPrev;

endmodule

`default_nettype wire

/* source/operandRegs.sv */
`default_nettype none

module operandRegs import aluPkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  byteT   dataByte,
  input  regSelT regSel,
  input  regSelT byteSel,
  input  logic   writeOrUseA,
  input  logic   loadEn,
  input  logic   arithEn,
  input  logic   mulStepEn,
  input  wordT   sum,
  output wordT   regA,
  output wordT   regB,
  output byteT   uo_out
);

  readSelT readSel;
  logic    writeEn;
  wordT    readWord;

  assign writeEn = loadEn && writeOrUseA;

  ////////////////////////////////////////
  // Register A, multiplicand during multiply
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      regA <= '0;
    else if (writeEn && (regSel == SelRegA))
      regA[byteSel*DataWidth +: DataWidth] <= dataByte;
    else if (mulStepEn)
      regA <= {regA[WordWidth-2:0], 1'b0};
  end

  ////////////////////////////////////////
  // Register B, accumulator
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      regB <= '0;
    else if (writeEn && (regSel == SelRegB))
      regB[byteSel*DataWidth +: DataWidth] <= dataByte;
    else if (arithEn || mulStepEn)
      regB <= sum;
  end

  // Load with the write flag low picks the output byte
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      readSel <= '0;
    else if (loadEn && !writeOrUseA)
      readSel <= {regSel, byteSel};
  end

  ////////////////////////////////////////
  // Output byte mux
  assign readWord = (readSel[1] == SelRegB) ? regB : regA;
  assign uo_out   = (readSel[0] == SelHigh) ? readWord[WordWidth-1 -: DataWidth]
                                            : readWord[DataWidth-1:0];

endmodule

`default_nettype wire

/* source/seqControl.sv */
`default_nettype none

module seqControl import aluPkg::*; #(
  parameter int MulSteps = DataWidth
) (
  input  logic CLK,
  input  logic RST,
  input  opT   op,
  input  logic writeOrUseA,
  input  logic startLevel,
  input  logic startRise,
  input  logic lastStep,
  output logic loadEn,
  output logic arithEn,
  output logic mulStepEn,
  output logic flagEn,
  output logic flagClr,
  output logic cntClr,
  output logic cntEn,
  output logic done
);

  seqStateT state;
  seqStateT nextState;
  logic     readOnly;

  // A read select keeps the flags of the previous result visible
  assign readOnly = (op == OpLoad) && !writeOrUseA;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      state <= Idle;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    loadEn    = 1'b0;
    arithEn   = 1'b0;
    mulStepEn = 1'b0;
    flagEn    = 1'b0;
    flagClr   = 1'b0;
    cntClr    = 1'b0;
    cntEn     = 1'b0;
    done      = 1'b0;
    case (state)
      Idle:
      begin
        if (startRise)
        begin
          nextState = Run;
          flagClr   = !readOnly;
          cntClr    = 1'b1;
        end
      end
      Run:
      begin
        case (op)
          OpLoad:
          begin
            loadEn    = 1'b1;
            nextState = Done;
          end
          OpAdd, OpSub:
          begin
            arithEn   = 1'b1;
            flagEn    = 1'b1;
            nextState = Done;
          end
          default:
            // Zero step multiply has nothing to do
            nextState = (MulSteps > 0) ? Step : Done;
        endcase
      end
      Step:
      begin
        mulStepEn = 1'b1;
        cntEn     = 1'b1;
        if (lastStep)
          nextState = Done;
      end
      default:
      begin
        done = 1'b1;
        if (!startLevel)
          nextState = Idle;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/stepCounter.sv */
`default_nettype none

module stepCounter import aluPkg::*; #(
  parameter int MulSteps = DataWidth
) (
  input  logic CLK,
  input  logic RST,
  input  logic cntClr,
  input  logic cntEn,
  output stepT stepIndex,
  output logic lastStep
);

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      stepIndex <= '0;
    else if (cntClr)
      stepIndex <= '0;
    else if (cntEn)
      stepIndex <= stepIndex + stepT'(1);
  end

  // Index of the final multiply step
  assign lastStep = (stepIndex == stepT'(MulSteps - 1));

endmodule

`default_nettype wire

/* tb/aluAsserts.sv */
`default_nettype none

module aluAsserts import aluPkg::*; (
  input logic     CLK,
  input logic     RST,
  input seqStateT state,
  input opT       op,
  input logic     startLevel,
  input logic     done,
  input logic     arithEn,
  input logic     mulStepEn
);
  timeunit 1ns;
  timeprecision 1ps;

  // No command and no done while waiting with start low
  idleDoneLow: assert property (@(posedge CLK) disable iff (!RST)
    (state == Idle && !startLevel) |=> (state == Idle && !done))
    else $error("unit left Idle or raised done while start was low");

  // Multiply steps only for a multiply, never with an accumulate
  enablesExclusive: assert property (@(posedge CLK) disable iff (!RST)
    mulStepEn |-> (!arithEn && op == OpMul))
    else $error("mulStepEn outside a multiply or together with arithEn");

  // Handshake release
  doneReleased: assert property (@(posedge CLK) disable iff (!RST)
    $fell(startLevel) |-> ##2 !done)
    else $error("done still high two cycles after start fell");

endmodule

`default_nettype wire

/* tb/aluTb.sv */
`default_nettype none

module aluTb import aluPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxWait = 50;

  logic CLK;
  logic RST;
  byteT ui_in;
  byteT uio_in;
  byteT uo_out;
  byteT uio_out;
  byteT uio_oe;

  int          errorCount;
  int          lastErrors;
  int          testCount;
  logic [15:0] lfsrState;

  aluTop #(
    .MulSteps (DataWidth)
  ) aluTop_i (
    .CLK     (CLK),
    .RST     (RST),
    .ui_in   (ui_in),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  bind aluTop aluAsserts aluAsserts_i (
    .CLK        (CLK),
    .RST        (RST),
    .state      (seqControl_i.state),
    .op         (op),
    .startLevel (startLevel),
    .done       (done),
    .arithEn    (arithEn),
    .mulStepEn  (mulStepEn)
  );

  always #20 CLK = ~CLK;

  ////////////////////////////////////////
  // Random data and result checks
  // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    lfsrNext = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic takeRandom(input int bits, output wordT value);
    value = '0;
    for (int i = 0; i < bits; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[WordWidth-2:0], lfsrState[0]};
    end
  endtask

  task automatic checkByte(input string name, input byteT got, input byteT exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkFlags(input logic expP, input logic expN);
    checkFlag("P", uio_out[4], expP);
    checkFlag("N", uio_out[3], expN);
    checkByte("uio_out spare bits", uio_out & 8'b1110_0011, 8'h00);
  endtask

  task automatic endTest(input string name);
    $display("Test %s finished with %0d errors", name, errorCount - lastErrors);
    lastErrors = errorCount;
    testCount++;
  endtask

  ////////////////////////////////////////
  // Command handshake
  task automatic waitDone(input logic level);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (uio_out[2] !== level && cycles < MaxWait)
    begin
      @(negedge CLK);
      cycles++;
    end
    if (uio_out[2] !== level)
    begin
      $display("Timeout at %0t: done did not go to %b", $time, level);
      errorCount++;
    end
  endtask

  task automatic runCommand(input logic sgn, input opT cmdOp, input regSelT sel,
                            input regSelT half, input logic flag, input byteT data);
    @(posedge CLK);
    #2;
    ui_in  = data;
    uio_in = {sgn, cmdOp, sel, half, flag, 1'b1, 1'b0};
    waitDone(1'b1);
    @(posedge CLK);
    #2;
    uio_in[1] = 1'b0;
    waitDone(1'b0);
  endtask

  task automatic readByte(input regSelT sel, input regSelT half, output byteT value);
    runCommand(1'b0, OpLoad, sel, half, 1'b0, 8'h00);
    value = uo_out;
  endtask

  task automatic loadWord(input regSelT sel, input wordT value);
    runCommand(1'b0, OpLoad, sel, 1'b0, 1'b1, value[7:0]);
    runCommand(1'b0, OpLoad, sel, 1'b1, 1'b1, value[15:8]);
  endtask

  task automatic checkWord(input string name, input regSelT sel, input wordT exp);
    byteT got;
    readByte(sel, 1'b0, got);
    checkByte({name, " low"}, got, exp[7:0]);
    readByte(sel, 1'b1, got);
    checkByte({name, " high"}, got, exp[15:8]);
  endtask

  // Unsigned accumulate, carry in P and borrow in N
  task automatic unsignedStep(input opT cmdOp, input byteT d, inout wordT b);
    logic [16:0] wide;
    logic        carry;
    logic        borrow;
    carry  = 1'b0;
    borrow = 1'b0;
    runCommand(1'b0, cmdOp, SelRegB, 1'b0, 1'b0, d);
    if (cmdOp == OpAdd)
    begin
      wide  = {1'b0, b} + {9'b0, d};
      carry = wide[16];
    end
    else
    begin
      wide   = {1'b0, b} - {9'b0, d};
      borrow = ({8'h00, d} > b);
    end
    b = wide[15:0];
    checkWord("B", SelRegB, b);
    checkFlags(carry, borrow);
  endtask

  // Signed add, overflow when the true sum leaves the 16 bit range
  task automatic signedStep(input logic useA, input byteT d, input wordT a, inout wordT b);
    wordT operand;
    int   full;
    operand = useA ? a : {{8{d[7]}}, d};
    full    = int'($signed(b)) + int'($signed(operand));
    runCommand(1'b1, OpAdd, SelRegB, 1'b0, useA, d);
    b = b + operand;
    checkWord("B", SelRegB, b);
    checkFlags((full > 32767) || (full < -32768), b[15]);
  endtask

  ////////////////////////////////////////
  // Directed tests
  task automatic testReset();
    byteT got;
    @(negedge CLK);
    checkFlag("done", uio_out[2], 1'b0);
    checkFlags(1'b0, 1'b0);
    checkByte("uio_oe", uio_oe, 8'b0001_1100);
    for (int r = 0; r < 2; r++)
      for (int h = 0; h < 2; h++)
      begin
        readByte(regSelT'(r), regSelT'(h), got);
        checkByte($sformatf("reg %0d byte %0d", r, h), got, 8'h00);
      end
    checkFlags(1'b0, 1'b0);
    endTest("reset");
  endtask

  task automatic testLoads();
    wordT a;
    wordT b;
    takeRandom(16, a);
    takeRandom(16, b);
    loadWord(SelRegA, a);
    loadWord(SelRegB, b);
    checkWord("A", SelRegA, a);
    checkWord("B", SelRegB, b);
    endTest("loads");
  endtask

  task automatic testUnsigned();
    wordT b;
    wordT r;
    b = 16'hFFF0;
    loadWord(SelRegB, b);
    unsignedStep(OpAdd, 8'h25, b);
    unsignedStep(OpSub, 8'h40, b);
    takeRandom(8, r);
    unsignedStep(OpAdd, r[7:0], b);
    takeRandom(8, r);
    unsignedStep(OpSub, r[7:0], b);
    endTest("unsigned");
  endtask

  task automatic testSigned();
    wordT a;
    wordT b;
    wordT r;
    b = 16'h0100;
    loadWord(SelRegB, b);
    signedStep(1'b0, 8'hF0, 16'h0000, b);
    signedStep(1'b0, 8'h80, 16'h0000, b);
    a = 16'h7FF0;
    b = 16'h0020;
    loadWord(SelRegA, a);
    loadWord(SelRegB, b);
    signedStep(1'b1, 8'h00, a, b);
    takeRandom(8, r);
    signedStep(1'b0, r[7:0], a, b);
    endTest("signed");
  endtask

  task automatic testMultiply();
    wordT a;
    wordT b;
    wordT r;
    for (int i = 0; i < 2; i++)
    begin
      takeRandom(16, a);
      takeRandom(16, b);
      takeRandom(8, r);
      loadWord(SelRegA, a);
      loadWord(SelRegB, b);
      runCommand(1'b0, OpMul, SelRegA, 1'b0, 1'b0, r[7:0]);
      checkWord("A", SelRegA, a << 8);
      checkWord("B", SelRegB, b + a * {8'h00, r[7:0]});
      checkFlags(1'b0, 1'b0);
    end
    endTest("multiply");
  endtask

  task automatic testRestart();
    loadWord(SelRegB, 16'h1234);
    runCommand(1'b0, OpAdd, SelRegB, 1'b0, 1'b0, 8'h11);
    runCommand(1'b0, OpAdd, SelRegB, 1'b0, 1'b0, 8'h22);
    checkWord("B", SelRegB, 16'h1267);
    endTest("restart");
  endtask

  initial
  begin
    CLK        = 1'b0;
    RST        = 1'b0;
    ui_in      = '0;
    uio_in     = '0;
    errorCount = 0;
    lastErrors = 0;
    testCount  = 0;
    lfsrState  = 16'd34;
    repeat (5) @(posedge CLK);
    #2;
    RST = 1'b1;
    testReset();
    testLoads();
    testUnsigned();
    testSigned();
    testMultiply();
    testRestart();
    $display("Tests run %0d, errors %0d", testCount, errorCount);
    if (errorCount == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire
